/* include/axi_defines.svh */
// Width and size macros shared by the AXI burst master, memory responder and queues
// Include wherever a width or depth is needed; the types live in axi_pkg

`ifndef AXI_DEFINES_SVH
`define AXI_DEFINES_SVH

// Byte address width
`define AXI_ADDR_WIDTH 16

// One beat is one 32-bit word
`define AXI_DATA_WIDTH 32

// Transaction ID width
`define AXI_ID_WIDTH 4

// 256 words, 1 KiB of memory behind the responder
`define MEM_WORDS_LOG2 8

// 16 entries, enough for the longest burst
`define BEAT_FIFO_DEPTH_LOG2 4

`endif

/* rtl/axi_burst_top.sv */
// Burst AXI master with its write and read beat queues, tied to an on-chip memory
// User pushes write beats then strobes start_write; read beats are drained with rd_pop

`timescale 1ns/100ps

module axi_burst_top (
	input  logic              clk,
	input  logic              resetn,
	input  logic              wr_push,
	input  axi_pkg::axi_w_t   wr_beat,     // last is ignored
	input  logic              start_write,
	input  axi_pkg::axi_cmd_t wr_cmd,
	input  logic              start_read,
	input  axi_pkg::axi_cmd_t rd_cmd,
	input  logic              rd_pop,
	output logic              wr_busy,
	output logic              rd_busy,
	output logic              wr_done,
	output axi_pkg::axi_b_t   wr_resp,
	output axi_pkg::axi_r_t   rd_beat,
	output logic              rd_avail,
	output logic              wr_space_ok
);

	axi_pkg::axi_w_t  wq_beat;
	axi_pkg::axi_r_t  rq_beat;
	logic             wq_pop, wq_not_empty;
	logic             rq_push, rq_not_full;

	axi_pkg::axi_ax_t aw, ar;
	axi_pkg::axi_w_t  w;
	axi_pkg::axi_b_t  b;
	axi_pkg::axi_r_t  r;
	logic             awvalid, awready, wvalid, wready, bvalid, bready;
	logic             arvalid, arready, rvalid, rready;

	beat_fifo #(.payload_t(axi_pkg::axi_w_t)) u_wr_fifo (
		.clk       (clk),
		.resetn    (resetn),
		.push      (wr_push),
		.din       (wr_beat),
		.pop       (wq_pop),
		.dout      (wq_beat),
		.not_empty (wq_not_empty),
		.not_full  (wr_space_ok)
	);

	beat_fifo #(.payload_t(axi_pkg::axi_r_t)) u_rd_fifo (
		.clk       (clk),
		.resetn    (resetn),
		.push      (rq_push),
		.din       (rq_beat),
		.pop       (rd_pop),
		.dout      (rd_beat),
		.not_empty (rd_avail),
		.not_full  (rq_not_full)
	);

	axi_write_engine u_wr (
		.clk (clk), .resetn (resetn),
		.start (start_write), .cmd (wr_cmd),
		.q_beat (wq_beat), .q_not_empty (wq_not_empty), .q_pop (wq_pop),
		.aw (aw), .awvalid (awvalid), .awready (awready),
		.w (w), .wvalid (wvalid), .wready (wready),
		.b (b), .bvalid (bvalid), .bready (bready),
		.busy (wr_busy), .done (wr_done), .resp (wr_resp)
	);

	axi_read_engine u_rd (
		.clk (clk), .resetn (resetn),
		.start (start_read), .cmd (rd_cmd),
		.q_not_full (rq_not_full), .q_push (rq_push), .q_beat (rq_beat),
		.ar (ar), .arvalid (arvalid), .arready (arready),
		.r (r), .rvalid (rvalid), .rready (rready),
		.busy (rd_busy)
	);

	axi_mem_slave u_mem (
		.clk (clk), .resetn (resetn),
		.aw (aw), .awvalid (awvalid), .awready (awready),
		.w (w), .wvalid (wvalid), .wready (wready),
		.b (b), .bvalid (bvalid), .bready (bready),
		.ar (ar), .arvalid (arvalid), .arready (arready),
		.r (r), .rvalid (rvalid), .rready (rready)
	);

endmodule

/* rtl/axi_mem_slave.sv */
// On-chip AXI memory responder, 32-bit words, byte strobes honoured
// Serves one write burst and one read burst at a time, each with its own FSM
// Beats past the end of memory are dropped or read as zero and answered with SLVERR

`timescale 1ns/100ps
`include "axi_defines.svh"

module axi_mem_slave (
	input  logic             clk,
	input  logic             resetn,
	input  axi_pkg::axi_ax_t aw,
	input  logic             awvalid,
	output logic             awready,
	input  axi_pkg::axi_w_t  w,
	input  logic             wvalid,
	output logic             wready,
	output axi_pkg::axi_b_t  b,
	output logic             bvalid,
	input  logic             bready,
	input  axi_pkg::axi_ax_t ar,
	input  logic             arvalid,
	output logic             arready,
	output axi_pkg::axi_r_t  r,
	output logic             rvalid,
	input  logic             rready
);

	localparam int MEM_WORDS = 1 << `MEM_WORDS_LOG2;
	localparam int IDX_HI    = `MEM_WORDS_LOG2 + 1;

	typedef enum logic [1:0] {
		W_IDLE,
		W_DATA,
		W_RESP
	} wstate_t;

	typedef enum logic {
		R_IDLE,
		R_DATA
	} rstate_t;

	wstate_t wstate;
	rstate_t rstate;

	logic [`AXI_DATA_WIDTH-1:0] mem [MEM_WORDS];

	axi_pkg::axi_ax_t           aw_q;
	axi_pkg::axi_ax_t           ar_q;
	logic                       aw_fire, w_fire, ar_fire, r_fire;
	logic [`AXI_ADDR_WIDTH-1:0] waddr, raddr;
	logic                       wcnt_last, rcnt_last;
	logic                       w_in_range, r_in_range;
	logic                       werr;

	assign aw_fire = awvalid && awready;
	assign w_fire  = wvalid && wready;
	assign ar_fire = arvalid && arready;
	assign r_fire  = rvalid && rready;

	burst_beat_counter u_wcnt (
		.clk        (clk),
		.resetn     (resetn),
		.load       (aw_fire),
		.start_addr (aw.addr),
		.beats_m1   (aw.len),
		.incr       (aw_q.burst == axi_pkg::BURST_INCR),
		.step       (w_fire),
		.addr       (waddr),
		.last       (wcnt_last)
	);

	burst_beat_counter u_rcnt (
		.clk        (clk),
		.resetn     (resetn),
		.load       (ar_fire),
		.start_addr (ar.addr),
		.beats_m1   (ar.len),
		.incr       (ar_q.burst == axi_pkg::BURST_INCR),
		.step       (r_fire),
		.addr       (raddr),
		.last       (rcnt_last)
	);

	// Word index must fit in the memory
	assign w_in_range = (waddr[`AXI_ADDR_WIDTH-1:IDX_HI+1] == '0);
	assign r_in_range = (raddr[`AXI_ADDR_WIDTH-1:IDX_HI+1] == '0);

	always_ff @(posedge clk) begin
		if (aw_fire)
			aw_q <= aw;
		if (ar_fire)
			ar_q <= ar;
		if (w_fire && w_in_range) begin
			for (int i = 0; i < `AXI_DATA_WIDTH / 8; i++) begin
				if (w.strb[i])
					mem[waddr[IDX_HI:2]][8*i +: 8] <= w.data[8*i +: 8];
			end
		end
	end

	// Write side
	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			wstate <= W_IDLE;
			werr   <= 1'b0;
		end else begin
			case (wstate)
				W_IDLE: if (aw_fire) begin
					wstate <= W_DATA;
					werr   <= 1'b0;
				end
				W_DATA: if (w_fire) begin
					if (!w_in_range || (w.last != wcnt_last))
						werr <= 1'b1; // Out of range, or wlast off its beat
					if (w.last)
						wstate <= W_RESP;
				end
				W_RESP: if (bvalid && bready) wstate <= W_IDLE;
				default: wstate <= W_IDLE;
			endcase
		end
	end

	assign awready = (wstate == W_IDLE);
	assign wready  = (wstate == W_DATA);
	assign bvalid  = (wstate == W_RESP);
	assign b.id    = aw_q.id;
	assign b.resp  = werr ? axi_pkg::RESP_SLVERR : axi_pkg::RESP_OKAY;

	// Read side
	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn)
			rstate <= R_IDLE;
		else if (rstate == R_IDLE && ar_fire)
			rstate <= R_DATA;
		else if (rstate == R_DATA && r_fire && rcnt_last)
			rstate <= R_IDLE;
	end

	assign arready = (rstate == R_IDLE);
	assign rvalid  = (rstate == R_DATA);
	assign r.id    = ar_q.id;
	assign r.data  = r_in_range ? mem[raddr[IDX_HI:2]] : '0;
	assign r.resp  = r_in_range ? axi_pkg::RESP_OKAY : axi_pkg::RESP_SLVERR;
	assign r.last  = rcnt_last;

endmodule

/* rtl/axi_pkg.sv */
// Channel payloads, user command and AXI code values for the burst master
// Refer to members as axi_pkg::name

`include "axi_defines.svh"

package axi_pkg;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	localparam logic [1:0] BURST_FIXED = 2'b00;
	localparam logic [1:0] BURST_INCR  = 2'b01;

	localparam logic [2:0] AXI_SIZE_WORD = 3'd2; // 4 bytes per beat

	// AW and AR share one layout
	typedef struct packed {
		logic [`AXI_ID_WIDTH-1:0]   id;
		logic [`AXI_ADDR_WIDTH-1:0] addr;
		logic [3:0]                 len;   // Beats minus one
		logic [2:0]                 size;
		logic [1:0]                 burst;
	} axi_ax_t;

	typedef struct packed {
		logic [`AXI_DATA_WIDTH-1:0]   data;
		logic [`AXI_DATA_WIDTH/8-1:0] strb;
		logic                         last;
	} axi_w_t;

	typedef struct packed {
		logic [`AXI_ID_WIDTH-1:0] id;
		logic [1:0]               resp;
	} axi_b_t;

	typedef struct packed {
		logic [`AXI_ID_WIDTH-1:0]   id;
		logic [`AXI_DATA_WIDTH-1:0] data;
		logic [1:0]                 resp;
		logic                       last;
	} axi_r_t;

	// What the user hands over with a start strobe
	typedef struct packed {
		logic [`AXI_ID_WIDTH-1:0]   id;
		logic [`AXI_ADDR_WIDTH-1:0] addr;
		logic [3:0]                 beats_m1;
		logic [1:0]                 burst;
	} axi_cmd_t;

endpackage

/* rtl/axi_read_engine.sv */
// AXI read master: one burst at a time over AR and R
// Accepted R beats go straight into the read queue; rlast ends the burst

`timescale 1ns/100ps

module axi_read_engine (
	input  logic              clk,
	input  logic              resetn,
	input  logic              start,
	input  axi_pkg::axi_cmd_t cmd,
	input  logic              q_not_full,
	output logic              q_push,
	output axi_pkg::axi_r_t   q_beat,
	output axi_pkg::axi_ax_t  ar,
	output logic              arvalid,
	input  logic              arready,
	input  axi_pkg::axi_r_t   r,
	input  logic              rvalid,
	output logic              rready
	,
	output logic              busy
);

	typedef enum logic [1:0] {
		IDLE,
		ADDR,
		DATA
	} state_t;

	state_t state, state_next;

	axi_pkg::axi_ax_t ar_q;
	logic             accept;

	assign accept = start && (state == IDLE);

	// Address beat is fixed for the whole burst, the responder steps it
	always_ff @(posedge clk) begin
		if (accept) begin
			ar_q.id    <= cmd.id;
			ar_q.addr  <= cmd.addr;
			ar_q.len   <= cmd.beats_m1;
			ar_q.size  <= axi_pkg::AXI_SIZE_WORD;
			ar_q.burst <= cmd.burst;
		end
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn)
			state <= IDLE;
		else
			state <= state_next;
	end

	always_comb begin
		state_next = state;
		case (state)
			IDLE: if (accept) state_next = ADDR;
			ADDR: if (arvalid && arready) state_next = DATA;
			DATA: if (q_push && r.last) state_next = IDLE;
			default: state_next = IDLE;
		endcase
	end

	assign ar      = ar_q;
	assign arvalid = (state == ADDR);
	assign rready  = (state == DATA) && q_not_full; // Full queue holds off the responder
	assign q_push  = rvalid && rready;
	assign q_beat  = r;
	assign busy    = (state != IDLE);

endmodule

/* rtl/axi_write_engine.sv */
// AXI write master: one burst at a time over AW, W and B
// Beats come from the write queue; wlast is set by the beat counter, not the queue
// done pulses with resp in the cycle B is taken

`timescale 1ns/100ps
`include "axi_defines.svh"

module axi_write_engine (
	input  logic              clk,
	input  logic              resetn,
	input  logic              start,
	input  axi_pkg::axi_cmd_t cmd,
	input  axi_pkg::axi_w_t   q_beat,
	input  logic              q_not_empty,
	output logic              q_pop,
	output axi_pkg::axi_ax_t  aw,
	output logic              awvalid,
	input  logic              awready,
	output axi_pkg::axi_w_t   w,
	output logic              wvalid,
	input  logic              wready,
	input  axi_pkg::axi_b_t   b,
	input  logic              bvalid,
	output logic              bready,
	output logic              busy,
	output logic              done,
	output axi_pkg::axi_b_t   resp
);

	typedef enum logic [1:0] {
		IDLE,
		ADDR,
		DATA,
		RESP
	} state_t;

	state_t state, state_next;

	axi_pkg::axi_cmd_t          cmd_q;
	logic                       accept;
	logic                       w_fire;
	logic [`AXI_ADDR_WIDTH-1:0] cnt_addr;
	logic                       cnt_last;

	assign accept = start && (state == IDLE); // Strobes while busy are dropped
	assign w_fire = wvalid && wready;

	always_ff @(posedge clk) begin
		if (accept)
			cmd_q <= cmd;
	end

	burst_beat_counter u_cnt (
		.clk        (clk),
		.resetn     (resetn),
		.load       (accept),
		.start_addr (cmd.addr),
		.beats_m1   (cmd.beats_m1),
		.incr       (cmd_q.burst == axi_pkg::BURST_INCR),
		.step       (w_fire),
		.addr       (cnt_addr),
		.last       (cnt_last)
	);

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn)
			state <= IDLE;
		else
			state <= state_next;
	end

	always_comb begin
		state_next = state;
		case (state)
			IDLE: if (accept) state_next = ADDR;
			ADDR: if (awvalid && awready) state_next = DATA;
			DATA: if (w_fire && cnt_last) state_next = RESP;
			RESP: if (bvalid && bready) state_next = IDLE;
			default: state_next = IDLE;
		endcase
	end

	always_comb begin
		aw.id    = cmd_q.id;
		aw.addr  = cnt_addr;       // Still the start address before the first beat
		aw.len   = cmd_q.beats_m1;
		aw.size  = axi_pkg::AXI_SIZE_WORD;
		aw.burst = cmd_q.burst;
		w.data   = q_beat.data;
		w.strb   = q_beat.strb;
		w.last   = cnt_last;
	end

	assign awvalid = (state == ADDR);
	assign wvalid  = (state == DATA) && q_not_empty; // Empty queue stalls the burst
	assign q_pop   = w_fire;
	assign bready  = (state == RESP);
	assign busy    = (state != IDLE);
	assign done    = bvalid && bready;
	assign resp    = b;

endmodule

/* rtl/beat_fifo.sv */
// Small circular queue for burst beats
// payload_t selects the beat type; dout shows the head entry before a pop
// Pushes when full and pops when empty are dropped

`timescale 1ns/100ps
`include "axi_defines.svh"

module beat_fifo #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     resetn,
	input  logic     push,
	input  payload_t din,
	input  logic     pop,
	output payload_t dout,
	output logic     not_empty,
	output logic     not_full
);

	localparam int PTR_W = `BEAT_FIFO_DEPTH_LOG2;
	localparam int DEPTH = 1 << PTR_W;

	payload_t mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;    // One extra bit to tell full from empty
	logic             do_push;
	logic             do_pop;

	assign do_push = push && not_full;
	assign do_pop  = pop && not_empty;

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	assign dout      = mem[rd_ptr];
	assign not_empty = (count != '0);
	assign not_full  = !count[PTR_W];

endmodule

/* rtl/burst_beat_counter.sv */
// Burst address and beat tracker for one AXI burst
// Pulse load with the start address and length, then step once per accepted beat

`timescale 1ns/100ps
`include "axi_defines.svh"

module burst_beat_counter (
	input  logic                       clk,
	input  logic                       resetn,
	input  logic                       load,
	input  logic [`AXI_ADDR_WIDTH-1:0] start_addr,
	input  logic [3:0]                 beats_m1,
	input  logic                       incr,
	input  logic                       step,
	output logic [`AXI_ADDR_WIDTH-1:0] addr,
	output logic                       last
);

	// Address step for a full-width beat
	localparam logic [`AXI_ADDR_WIDTH-1:0] WORD_BYTES = `AXI_DATA_WIDTH / 8;

	logic [3:0] len_q;
	logic [3:0] beat_q;

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			addr   <= '0;
			len_q  <= '0;
			beat_q <= '0;
		end else if (load) begin
			addr   <= start_addr;
			len_q  <= beats_m1;
			beat_q <= '0;
		end else if (step) begin
			if (incr)
				addr <= addr + WORD_BYTES; // FIXED bursts hold the address
			beat_q <= beat_q + 4'd1;
		end
	end

	assign last = (beat_q == len_q);

endmodule

/* tb/tb_axi_burst_top.sv */
// Self-checking testbench for the AXI burst master and memory responder
// LFSR stimulus runs against a word model of the memory; inputs change on the falling edge
// Covers reset state, INCR and FIXED bursts, past-end errors, back-pressure and slow pushes

`timescale 1ns/100ps
`include "axi_defines.svh"

module tb_axi_burst_top;

	localparam int MEM_WORDS   = 1 << `MEM_WORDS_LOG2;
	localparam int FIFO_DEPTH  = 1 << `BEAT_FIFO_DEPTH_LOG2;
	localparam int N_RANDOM    = 6;
	// Fill, random pairs, FIXED pair, past-end pair, back-pressure, slow pair
	localparam int NUM_BURSTS  = 16 + 2 * N_RANDOM + 2 + 2 + 3 + 2;
	localparam int CYCLE_LIMIT = 40 * NUM_BURSTS + 16;

	logic              clk = 1'b0;
	logic              resetn;
	logic              wr_push;
	axi_pkg::axi_w_t   wr_beat;
	logic              start_write;
	axi_pkg::axi_cmd_t wr_cmd;
	logic              start_read;
	axi_pkg::axi_cmd_t rd_cmd;
	logic              rd_pop;
	logic              wr_busy;
	logic              rd_busy;
	logic              wr_done;
	axi_pkg::axi_b_t   wr_resp;
	axi_pkg::axi_r_t   rd_beat;
	logic              rd_avail;
	logic              wr_space_ok;

	logic [15:0]                lfsr_state = 16'd1753;
	logic [`AXI_DATA_WIDTH-1:0] model_mem [MEM_WORDS];
	logic [`AXI_DATA_WIDTH-1:0] beat_data [16];
	logic [3:0]                 beat_strb [16];
	axi_pkg::axi_r_t            exp_beats [$];
	int                         done_count = 0;
	axi_pkg::axi_b_t            done_resp;
	int                         cycle_count = 0;

	axi_burst_top dut0 (
		.clk         (clk),
		.resetn      (resetn),
		.wr_push     (wr_push),
		.wr_beat     (wr_beat),
		.start_write (start_write),
		.wr_cmd      (wr_cmd),
		.start_read  (start_read),
		.rd_cmd      (rd_cmd),
		.rd_pop      (rd_pop),
		.wr_busy     (wr_busy),
		.rd_busy     (rd_busy),
		.wr_done     (wr_done),
		.wr_resp     (wr_resp),
		.rd_beat     (rd_beat),
		.rd_avail    (rd_avail),
		.wr_space_ok (wr_space_ok)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TESTS FAILED");
			$fatal(1, "simulation stopped on timeout");
		end
	end

	// Fibonacci LFSR, taps 16 14 13 11, one step per bit
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] v;
		logic        fb;
		int          i;
		v = '0;
		for (i = 0; i < n; i++) begin
			fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic logic [31:0] fill_word(input logic [7:0] idx);
		return {idx ^ 8'hA5, ~idx, idx, idx + 8'h3B};
	endfunction

	function automatic logic [`AXI_ADDR_WIDTH-1:0] beat_addr(input axi_pkg::axi_cmd_t cmd,
		input int i);
		if (cmd.burst == axi_pkg::BURST_INCR)
			return cmd.addr + `AXI_ADDR_WIDTH'(i * 4);
		return cmd.addr; // FIXED repeats the start
	endfunction

	function automatic logic addr_in_range(input logic [`AXI_ADDR_WIDTH-1:0] addr);
		return int'(addr) < MEM_WORDS * 4;
	endfunction

	// Applies one beat to the model, returns 0 when it falls past the end
	function automatic logic store_beat(input axi_pkg::axi_cmd_t cmd, input int i);
		logic [`AXI_ADDR_WIDTH-1:0] addr;
		int                         b;
		addr = beat_addr(cmd, i);
		if (!addr_in_range(addr))
			return 1'b0;
		for (b = 0; b < 4; b++) begin
			if (beat_strb[i][b])
				model_mem[addr >> 2][8*b +: 8] = beat_data[i][8*b +: 8];
		end
		return 1'b1;
	endfunction

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected) begin
			$display("error %s: expected %0h, actual %0h", name, expected, actual);
			$display("TESTS FAILED");
			$fatal(1, "check failed");
		end
	endtask

	// One cycle; outputs sampled at the falling edge, before new inputs go out
	task automatic tick();
		@(negedge clk);
		if (wr_done === 1'b1) begin
			done_count = done_count + 1;
			done_resp = wr_resp;
		end
	endtask

	task automatic push_beat(input int i);
		wr_beat.data = beat_data[i];
		wr_beat.strb = beat_strb[i];
		wr_beat.last = 1'b0;
		wr_push = 1'b1;
		tick();
		wr_push = 1'b0;
	endtask

	task automatic issue_write(input axi_pkg::axi_cmd_t cmd);
		wr_cmd = cmd;
		start_write = 1'b1;
		tick();
		start_write = 1'b0;
	endtask

	task automatic issue_read(input axi_pkg::axi_cmd_t cmd);
		rd_cmd = cmd;
		start_read = 1'b1;
		tick();
		start_read = 1'b0;
	endtask

	task automatic write_burst(input axi_pkg::axi_cmd_t cmd, input logic slow);
		int              n;
		int              i;
		int              gap;
		int              done_before;
		axi_pkg::axi_b_t exp_b;
		n = int'(cmd.beats_m1) + 1;
		done_before = done_count;
		if (slow) begin
			issue_write(cmd); // Engine stalls on the empty queue
			for (i = 0; i < n; i++) begin
				gap = lfsr_bits(2);
				repeat (gap) tick();
				push_beat(i);
			end
		end else begin
			for (i = 0; i < n; i++)
				push_beat(i);
			// Queue holds all n beats, full only for the longest burst
			check_value("wr_space_ok after pushes", n < FIFO_DEPTH, wr_space_ok);
			issue_write(cmd);
		end
		while (done_count == done_before)
			tick();
		tick();
		exp_b.id = cmd.id;
		exp_b.resp = axi_pkg::RESP_OKAY;
		for (i = 0; i < n; i++) begin
			if (!store_beat(cmd, i))
				exp_b.resp = axi_pkg::RESP_SLVERR;
		end
		check_value("write response", exp_b, done_resp);
		check_value("wr_done pulse count", done_before + 1, done_count);
		check_value("wr_busy after done", 0, wr_busy);
	endtask

	task automatic expect_read(input axi_pkg::axi_cmd_t cmd);
		axi_pkg::axi_r_t            e;
		logic [`AXI_ADDR_WIDTH-1:0] addr;
		int                         i;
		for (i = 0; i <= int'(cmd.beats_m1); i++) begin
			addr = beat_addr(cmd, i);
			e.id = cmd.id;
			e.data = addr_in_range(addr) ? model_mem[addr >> 2] : '0;
			e.resp = addr_in_range(addr) ? axi_pkg::RESP_OKAY : axi_pkg::RESP_SLVERR;
			e.last = (i == int'(cmd.beats_m1));
			exp_beats.push_back(e);
		end
	endtask

	task automatic drain_reads();
		int k;
		k = 0;
		while (exp_beats.size() > 0) begin
			if (rd_avail) begin
				check_value($sformatf("read beat %0d", k), exp_beats[0], rd_beat);
				void'(exp_beats.pop_front());
				k++;
				rd_pop = 1'b1;
			end else begin
				rd_pop = 1'b0;
			end
			tick();
		end
		rd_pop = 1'b0;
		check_value("read queue empty after burst", 0, rd_avail);
		check_value("rd_busy after burst", 0, rd_busy);
	endtask

	task automatic read_burst(input axi_pkg::axi_cmd_t cmd);
		expect_read(cmd);
		issue_read(cmd);
		drain_reads();
	endtask

	// Known contents everywhere before random strobes are used
	task automatic fill_memory();
		axi_pkg::axi_cmd_t cmd;
		int                blk;
		int                i;
		for (blk = 0; blk < MEM_WORDS / 16; blk++) begin
			cmd.id = blk[3:0];
			cmd.addr = `AXI_ADDR_WIDTH'(blk * 64);
			cmd.beats_m1 = 4'd15;
			cmd.burst = axi_pkg::BURST_INCR;
			for (i = 0; i < 16; i++) begin
				beat_data[i] = fill_word(8'(blk * 16 + i));
				beat_strb[i] = 4'hF;
			end
			write_burst(cmd, 1'b0);
		end
	endtask

	task automatic random_pair(input logic slow);
		axi_pkg::axi_cmd_t cmd;
		int                n;
		int                word;
		int                i;
		cmd.id = lfsr_bits(4);
		cmd.beats_m1 = lfsr_bits(4);
		n = int'(cmd.beats_m1) + 1;
		word = lfsr_bits(8);
		if (word + n > MEM_WORDS)
			word = MEM_WORDS - n; // Keep the burst inside memory
		cmd.addr = `AXI_ADDR_WIDTH'(word * 4);
		cmd.burst = axi_pkg::BURST_INCR;
		for (i = 0; i < n; i++) begin
			beat_data[i] = lfsr_bits(32);
			beat_strb[i] = lfsr_bits(4);
		end
		write_burst(cmd, slow);
		read_burst(cmd);
	endtask

	task automatic fixed_test();
		axi_pkg::axi_cmd_t cmd;
		int                i;
		cmd.id = lfsr_bits(4);
		cmd.beats_m1 = lfsr_bits(4) | 4'd1;
		cmd.addr = `AXI_ADDR_WIDTH'(lfsr_bits(8) * 4);
		cmd.burst = axi_pkg::BURST_FIXED;
		for (i = 0; i <= int'(cmd.beats_m1); i++) begin
			beat_data[i] = lfsr_bits(32);
			beat_strb[i] = lfsr_bits(4);
		end
		beat_strb[cmd.beats_m1] = 4'hF; // Final beat owns the whole word
		write_burst(cmd, 1'b0);
		read_burst(cmd);
	endtask

	task automatic past_end_test();
		axi_pkg::axi_cmd_t cmd;
		int                i;
		cmd.id = lfsr_bits(4);
		cmd.beats_m1 = 4'd9;
		cmd.addr = `AXI_ADDR_WIDTH'((MEM_WORDS - 6) * 4); // Last 4 beats out of range
		cmd.burst = axi_pkg::BURST_INCR;
		for (i = 0; i < 10; i++) begin
			beat_data[i] = lfsr_bits(32);
			beat_strb[i] = 4'hF;
		end
		write_burst(cmd, 1'b0);
		read_burst(cmd);
	endtask

	task automatic backpressure_test();
		axi_pkg::axi_cmd_t full_cmd;
		axi_pkg::axi_cmd_t extra_cmd;
		int                i;
		full_cmd.id = lfsr_bits(4);
		full_cmd.beats_m1 = 4'd15;
		full_cmd.addr = `AXI_ADDR_WIDTH'((lfsr_bits(8) & 32'hF0) * 4);
		full_cmd.burst = axi_pkg::BURST_INCR;
		for (i = 0; i < 16; i++) begin
			beat_data[i] = lfsr_bits(32);
			beat_strb[i] = lfsr_bits(4);
		end
		write_burst(full_cmd, 1'b0);
		expect_read(full_cmd);
		issue_read(full_cmd);
		while (rd_busy)
			tick();
		// Queue now full, so the next burst has to wait on rready
		extra_cmd = full_cmd;
		extra_cmd.id = full_cmd.id + 4'd1;
		extra_cmd.beats_m1 = 4'd7;
		expect_read(extra_cmd);
		issue_read(extra_cmd);
		repeat (16) tick(); // Longer than an unblocked 8-beat read would take
		check_value("read held by full queue", 1, rd_busy);
		drain_reads();
	endtask

	initial begin
		resetn = 1'b0;
		wr_push = 1'b0;
		wr_beat = '0;
		start_write = 1'b0;
		wr_cmd = '0;
		start_read = 1'b0;
		rd_cmd = '0;
		rd_pop = 1'b0;
		repeat (16) tick();
		resetn = 1'b1;
		tick();

		check_value("wr_busy after reset", 0, wr_busy);
		check_value("rd_busy after reset", 0, rd_busy);
		check_value("wr_done after reset", 0, wr_done);
		check_value("rd_avail after reset", 0, rd_avail);
		check_value("wr_space_ok after reset", 1, wr_space_ok);

		fill_memory();
		repeat (N_RANDOM) random_pair(1'b0);
		fixed_test();
		past_end_test();
		backpressure_test();
		random_pair(1'b1); // Beats trickle in with gaps

		$display("TESTS PASSED");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+include
rtl/axi_pkg.sv
rtl/burst_beat_counter.sv
rtl/beat_fifo.sv
rtl/axi_write_engine.sv
rtl/axi_read_engine.sv
rtl/axi_mem_slave.sv
rtl/axi_burst_top.sv
tb/tb_axi_burst_top.sv
